// File: design/pwm_pkg.sv
// shared PWM channel types; address map assumes 4 registers per channel from address 16
package pwm_pkg;

   // widths that carry a meaning
   typedef logic [7:0]  reg_addr_t;
   typedef logic [31:0] reg_data_t;
   typedef logic [31:0] pwm_time_t;

   // address map
   localparam reg_addr_t pwm_base          = 8'd16;
   localparam reg_addr_t nos_pwm_registers = 8'd4;

   // register offsets inside one channel window
   localparam logic [1:0] pwm_period  = 2'd0;
   localparam logic [1:0] pwm_on_time = 2'd1;
   localparam logic [1:0] pwm_config  = 2'd2;
   localparam logic [1:0] pwm_status  = 2'd3;

   // config register bit positions, low bit for the 2-bit fields
   localparam int cfg_enable        = 0;
   localparam int cfg_bridge_enable = 1;
   localparam int cfg_bridge_mode   = 2;
   localparam int cfg_dwell         = 4;
   localparam int cfg_invert        = 5;

   // one register access, issued once per bus transfer
   typedef struct packed {
      logic       write;
      logic       read;
      logic [1:0] offset;
      reg_data_t  data;
   } reg_cmd_t;

   typedef struct packed {
      logic      enable;
      pwm_time_t period;
      pwm_time_t on_time;
   } pwm_ctrl_t;

   typedef struct packed {
      logic       enable;
      logic [1:0] mode;
      logic       dwell;
      logic [1:0] invert;
   } bridge_cfg_t;

   typedef enum logic [1:0] {bus_idle, bus_xfer, bus_ack} bus_state_t;

   typedef enum logic [1:0] {pwm_off, pwm_load, pwm_high, pwm_low} pwm_state_t;

endpackage

// File: design/bus_handshake.sv
// four-phase slave; addresses outside the window are never acknowledged, host must time out
module bus_handshake
   import pwm_pkg::*;
#(
   parameter int pwm_unit = 0
) (
   input  logic      clk,
   input  logic      reset,
   input  logic      handshake_1,
   input  logic      rw,
   input  reg_addr_t reg_address,
   input  reg_data_t write_data,
   output logic      handshake_2,
   output reg_cmd_t  cmd
);

   localparam reg_addr_t window_base =
      reg_addr_t'(pwm_base + pwm_unit * nos_pwm_registers);

   bus_state_t state;
   bus_state_t next_state;
   reg_addr_t  rel_address;
   logic       in_window;

   // below the base the subtraction wraps to a large value
   assign rel_address = reg_address - window_base;
   assign in_window   = rel_address < nos_pwm_registers;

   always_comb begin
      next_state = state;
      case (state)
         bus_idle: begin
            if (handshake_1 && in_window) begin
               next_state = bus_xfer;
            end
         end
         bus_xfer: begin
            next_state = bus_ack;
         end
         bus_ack: begin
            if (!handshake_1) begin
               next_state = bus_idle;
            end
         end
         default: begin
            next_state = bus_idle;
         end
      endcase
   end

   // ack rises one edge after entering bus_ack, so read data is already settled
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state       <= bus_idle;
         handshake_2 <= 1'b0;
      end else begin
         state       <= next_state;
         handshake_2 <= (state == bus_ack) && handshake_1;
      end
   end

   always_comb begin
      cmd.write  = (state == bus_xfer) && rw;
      cmd.read   = (state == bus_xfer) && !rw;
      cmd.offset = rel_address[1:0];
      cmd.data   = write_data;
   end

   ack_follows_request: assert property (@(posedge clk) disable iff (!reset)
      $rose(handshake_2) |-> $past(handshake_1));

   single_command: assert property (@(posedge clk) disable iff (!reset)
      !(cmd.write && cmd.read));

endmodule

// File: design/pwm_registers.sv
// period, on-time and config; writing period or on-time drops the enable bit
module pwm_registers
   import pwm_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  reg_cmd_t    cmd,
   input  logic        pwm,
   output reg_data_t   read_data,
   output pwm_ctrl_t   ctrl,
   output bridge_cfg_t bridge
);

   pwm_time_t period_reg;
   pwm_time_t on_time_reg;
   reg_data_t config_reg;
   reg_data_t status_word;

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         period_reg  <= '0;
         on_time_reg <= '0;
         config_reg  <= '0;
      end else if (cmd.write) begin
         case (cmd.offset)
            pwm_period: begin
               period_reg             <= cmd.data;
               // timer must not run on half of a new pair
               config_reg[cfg_enable] <= 1'b0;
            end
            pwm_on_time: begin
               on_time_reg            <= cmd.data;
               config_reg[cfg_enable] <= 1'b0;
            end
            pwm_config: begin
               config_reg <= cmd.data;
            end
            default: begin
               // status is read only
            end
         endcase
      end
   end

   assign status_word = {pwm, 15'b0, config_reg[15:0]};

   // captured in bus_xfer, held for the whole ack phase
   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         read_data <= '0;
      end else if (cmd.read) begin
         case (cmd.offset)
            pwm_period:  read_data <= period_reg;
            pwm_on_time: read_data <= on_time_reg;
            pwm_config:  read_data <= config_reg;
            default:     read_data <= status_word;
         endcase
      end
   end

   assign ctrl.enable   = config_reg[cfg_enable];
   assign ctrl.period   = period_reg;
   assign ctrl.on_time  = on_time_reg;

   assign bridge.enable = config_reg[cfg_bridge_enable];
   assign bridge.mode   = config_reg[cfg_bridge_mode +: 2];
   assign bridge.dwell  = config_reg[cfg_dwell];
   assign bridge.invert = config_reg[cfg_invert +: 2];

   read_data_on_read_only: assert property (@(posedge clk) disable iff (!reset)
      $changed(read_data) |-> $past(cmd.read));

endmodule

// File: design/pwm_timer.sv
// exact PWM for period >= 2; on-time above period is clipped to a full-high period
module pwm_timer
   import pwm_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  pwm_ctrl_t ctrl,
   output logic      pwm
);

   pwm_state_t state;
   pwm_state_t next_state;
   pwm_time_t  period_cnt;
   pwm_time_t  on_cnt;
   pwm_time_t  period_left;
   pwm_time_t  on_left;

   // cycles still to go once the load cycle is spent
   assign period_left = (ctrl.period == '0) ? '0 : ctrl.period - 1'b1;
   assign on_left     = (ctrl.on_time == '0) ? '0 : ctrl.on_time - 1'b1;

   always_comb begin
      next_state = state;
      if (!ctrl.enable) begin
         next_state = pwm_off;
      end else begin
         case (state)
            pwm_off: begin
               next_state = pwm_load;
            end
            pwm_load: begin
               // a one-cycle period just reloads
               if (period_left == '0) begin
                  next_state = pwm_load;
               end else if (on_left != '0) begin
                  next_state = pwm_high;
               end else begin
                  next_state = pwm_low;
               end
            end
            pwm_high: begin
               if (period_cnt == 1) begin
                  next_state = pwm_load;
               end else if (on_cnt == 1) begin
                  next_state = pwm_low;
               end
            end
            pwm_low: begin
               if (period_cnt == 1) begin
                  next_state = pwm_load;
               end
            end
            default: begin
               next_state = pwm_off;
            end
         endcase
      end
   end

   always_ff @(posedge clk or negedge reset) begin
      if (!reset) begin
         state      <= pwm_off;
         period_cnt <= '0;
         on_cnt     <= '0;
      end else begin
         state <= next_state;
         if (state == pwm_load) begin
            period_cnt <= period_left;
            on_cnt     <= on_left;
         end else if (state == pwm_high || state == pwm_low) begin
            period_cnt <= period_cnt - 1'b1;
            if (state == pwm_high) begin
               on_cnt <= on_cnt - 1'b1;
            end
         end
      end
   end

   // load cycle is the first high cycle unless on-time is zero
   assign pwm = (state == pwm_high) || ((state == pwm_load) && (ctrl.on_time != '0));

   off_after_disable: assert property (@(posedge clk) disable iff (!reset)
      !ctrl.enable |=> (state == pwm_off) && !pwm);

endmodule

// File: design/h_bridge_drive.sv
// combinational pin map; no dead-time insertion between direction changes
module h_bridge_drive
   import pwm_pkg::*;
(
   input  logic        pwm,
   input  bridge_cfg_t bridge,
   output logic        h_bridge_1,
   output logic        h_bridge_2
);

   // bit 0 is pin 1, bit 1 is pin 2
   logic [1:0] pins;

   always_comb begin
      pins = 2'b00;
      if (bridge.enable) begin
         case (bridge.mode)
            // coast
            2'd0: pins = 2'b00;
            // forward, dwell brakes in the low phase
            2'd1: pins = {!pwm && bridge.dwell, pwm || bridge.dwell};
            // reverse
            2'd2: pins = {pwm || bridge.dwell, !pwm && bridge.dwell};
            // brake
            default: pins = 2'b11;
         endcase
      end
   end

   // inversion applies even with the bridge disabled
   assign h_bridge_1 = pins[0] ^ bridge.invert[0];
   assign h_bridge_2 = pins[1] ^ bridge.invert[1];

endmodule

// File: design/pwm_channel.sv
// one PWM channel; read_data is only meaningful while handshake_2 is high
module pwm_channel
   import pwm_pkg::*;
#(
   parameter int pwm_unit = 0
) (
   input  logic      clk,
   input  logic      reset,
   input  logic      handshake_1,
   input  logic      rw,
   input  reg_addr_t reg_address,
   input  reg_data_t write_data,
   output logic      handshake_2,
   output reg_data_t read_data,
   output logic      pwm_signal,
   output logic      h_bridge_1,
   output logic      h_bridge_2
);

   reg_cmd_t    cmd;
   pwm_ctrl_t   ctrl;
   bridge_cfg_t bridge;

   bus_handshake #(.pwm_unit(pwm_unit)) i_bus_handshake (
      .clk(clk),
      .reset(reset),
      .handshake_1(handshake_1),
      .rw(rw),
      .reg_address(reg_address),
      .write_data(write_data),
      .handshake_2(handshake_2),
      .cmd(cmd)
   );

   // status word reads the live waveform back
   pwm_registers i_pwm_registers (
      .clk(clk),
      .reset(reset),
      .cmd(cmd),
      .pwm(pwm_signal),
      .read_data(read_data),
      .ctrl(ctrl),
      .bridge(bridge)
   );

   pwm_timer i_pwm_timer (
      .clk(clk),
      .reset(reset),
      .ctrl(ctrl),
      .pwm(pwm_signal)
   );

   h_bridge_drive i_h_bridge_drive (
      .pwm(pwm_signal),
      .bridge(bridge),
      .h_bridge_1(h_bridge_1),
      .h_bridge_2(h_bridge_2)
   );

endmodule

// File: sim/pwm_channel_tb.sv
// runs pwm_unit 1 (window 20 to 23); fixed LFSR seed, waveform trials keep period within 2 to 40
module pwm_channel_tb
   import pwm_pkg::*;
;

   localparam reg_addr_t window_base = 8'd20;
   localparam int ack_limit = 20;
   // 12 trials of at most 300 cycles, plus reset, register rounds and margin
   localparam int max_cycles = 4000;

   logic      clk;
   logic      reset;
   logic      handshake_1;
   logic      rw;
   reg_addr_t reg_address;
   reg_data_t write_data;
   logic      handshake_2;
   reg_data_t read_data;
   logic      pwm_signal;
   logic      h_bridge_1;
   logic      h_bridge_2;

   reg_data_t   model_period;
   reg_data_t   model_on_time;
   reg_data_t   model_config;
   logic [15:0] lfsr_state;
   int          error_count = 0;
   int          check_count = 0;
   int          cycle_count = 0;

   pwm_channel #(.pwm_unit(1)) i_dut (
      .clk(clk),
      .reset(reset),
      .handshake_1(handshake_1),
      .rw(rw),
      .reg_address(reg_address),
      .write_data(write_data),
      .handshake_2(handshake_2),
      .read_data(read_data),
      .pwm_signal(pwm_signal),
      .h_bridge_1(h_bridge_1),
      .h_bridge_2(h_bridge_2)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= max_cycles) begin
         $display("timeout after %0d cycles, the tests did not finish", cycle_count);
         $display("checks=%0d errors=%0d", check_count, error_count);
         $display("Test failed");
         $finish;
      end
   end

   // taps 16 14 13 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic reg_data_t random_bits(input int n);
      reg_data_t value;
      int        i;
      value = '0;
      for (i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         value      = {value[30:0], lfsr_state[0]};
      end
      return value;
   endfunction

   // {pin 2, pin 1} from the bridge mode table
   function automatic logic [1:0] expected_pins(input reg_data_t cfg, input logic pwm);
      logic [1:0] pins;
      pins = 2'b00;
      if (cfg[cfg_bridge_enable]) begin
         case (cfg[cfg_bridge_mode +: 2])
            2'd1:    pins = pwm ? 2'b01 : {2{cfg[cfg_dwell]}};
            2'd2:    pins = pwm ? 2'b10 : {2{cfg[cfg_dwell]}};
            2'd3:    pins = 2'b11;
            default: pins = 2'b00;
         endcase
      end
      return pins ^ {cfg[cfg_invert + 1], cfg[cfg_invert]};
   endfunction

   task automatic check(input string name, input reg_data_t actual, input reg_data_t expected);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("FAIL time=%0t signal=%s actual=0x%08h expected=0x%08h",
                  $time, name, actual, expected);
      end
   endtask

   // outputs are sampled and inputs driven 2 units after the edge
   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic bus_access(input reg_addr_t addr, input logic write, input reg_data_t data,
                             output logic ack_seen, output reg_data_t data_seen);
      int waited;
      handshake_1 = 1'b1;
      rw          = write;
      reg_address = addr;
      write_data  = data;
      ack_seen    = 1'b0;
      data_seen   = '0;
      waited      = 0;
      while (!ack_seen && waited < ack_limit) begin
         step();
         waited++;
         ack_seen = handshake_2;
      end
      if (ack_seen) begin
         // request sampled on the first edge, ack raised two edges later
         check("handshake_2 delay", waited, 32'd3);
         data_seen = read_data;
      end
      handshake_1 = 1'b0;
      waited      = 0;
      while (handshake_2 && waited < ack_limit) begin
         step();
         waited++;
      end
      if (handshake_2) begin
         error_count++;
         $display("acknowledge stayed high after the request dropped, time %0t", $time);
      end
   endtask

   task automatic reg_write(input logic [1:0] offset, input reg_data_t data);
      logic      ack_seen;
      reg_data_t data_seen;
      bus_access(window_base + {6'b0, offset}, 1'b1, data, ack_seen, data_seen);
      if (!ack_seen) begin
         error_count++;
         $display("no acknowledge for a write to offset %0d, time %0t", offset, $time);
      end
      case (offset)
         pwm_period: begin
            model_period              = data;
            model_config[cfg_enable] = 1'b0;
         end
         pwm_on_time: begin
            model_on_time             = data;
            model_config[cfg_enable] = 1'b0;
         end
         pwm_config: model_config = data;
         default: ;
      endcase
   endtask

   task automatic read_check(input logic [1:0] offset);
      logic      ack_seen;
      reg_data_t data_seen;
      reg_data_t mask;
      bus_access(window_base + {6'b0, offset}, 1'b0, '0, ack_seen, data_seen);
      if (!ack_seen) begin
         error_count++;
         $display("no acknowledge for a read of offset %0d, time %0t", offset, $time);
      end else begin
         case (offset)
            pwm_period:  check("period", data_seen, model_period);
            pwm_on_time: check("on_time", data_seen, model_on_time);
            pwm_config:  check("config", data_seen, model_config);
            default: begin
               // the live pwm bit is only predictable with the timer stopped
               mask = model_config[cfg_enable] ? 32'h7fff_ffff : 32'hffff_ffff;
               check("status", data_seen & mask, {16'b0, model_config[15:0]} & mask);
            end
         endcase
      end
   endtask

   task automatic read_all();
      logic [2:0] i;
      for (i = 3'd0; i < 3'd4; i++) begin
         read_check(i[1:0]);
      end
   endtask

   task automatic watch_cycle();
      step();
      check("h_bridge_2:h_bridge_1", {30'b0, h_bridge_2, h_bridge_1},
            {30'b0, expected_pins(model_config, pwm_signal)});
   endtask

   task automatic waveform_trial();
      reg_data_t period_val;
      reg_data_t on_val;
      reg_data_t count;
      reg_data_t cycles;
      reg_data_t high;
      logic      prev;
      logic      rose;
      int        k;
      period_val = 32'd2 + random_bits(6) % 32'd39;
      on_val     = random_bits(6) % (period_val + 32'd1);
      reg_write(pwm_period, period_val);
      reg_write(pwm_on_time, on_val);
      // random bridge fields in bits 6 to 1, enable set
      reg_write(pwm_config, (random_bits(6) << 1) | 32'd1);
      if (on_val == 32'd0 || on_val == period_val) begin
         for (count = 32'd0; count < 32'd3 * period_val + 32'd4; count++) begin
            watch_cycle();
            check("pwm_signal", {31'b0, pwm_signal}, {31'b0, on_val != 32'd0});
         end
      end else begin
         prev  = pwm_signal;
         rose  = 1'b0;
         count = 32'd0;
         while (!rose && count < 32'd2 * period_val + 32'd4) begin
            watch_cycle();
            rose = !prev && pwm_signal;
            prev = pwm_signal;
            count++;
         end
         if (!rose) begin
            error_count++;
            $display("no rising edge on pwm_signal for period %0d on-time %0d",
                     period_val, on_val);
         end else begin
            for (k = 0; k < 3; k++) begin
               cycles = 32'd1;
               high   = 32'd1;
               rose   = 1'b0;
               while (!rose && cycles <= 32'd2 * period_val) begin
                  watch_cycle();
                  rose = !prev && pwm_signal;
                  prev = pwm_signal;
                  if (!rose) begin
                     cycles++;
                     high = high + {31'b0, pwm_signal};
                  end
               end
               check("pwm period cycles", cycles, period_val);
               check("pwm high cycles", high, on_val);
            end
         end
      end
   endtask

   initial begin
      reg_data_t pick;
      reg_addr_t stray_addr;
      logic      ack_seen;
      reg_data_t data_seen;
      reset         = 1'b0;
      handshake_1   = 1'b0;
      rw            = 1'b0;
      reg_address   = '0;
      write_data    = '0;
      lfsr_state    = 16'd13221;
      model_period  = '0;
      model_on_time = '0;
      model_config  = '0;
      repeat (16) @(posedge clk);
      #2;
      reset = 1'b1;

      // state straight after reset
      check("pwm_signal", {31'b0, pwm_signal}, '0);
      check("h_bridge_1", {31'b0, h_bridge_1}, '0);
      check("h_bridge_2", {31'b0, h_bridge_2}, '0);
      check("read_data", read_data, '0);
      read_all();

      // config with enable, then the pair that clears it again
      repeat (3) begin
         reg_write(pwm_config, random_bits(32) | 32'd1);
         reg_write(pwm_period, random_bits(32));
         reg_write(pwm_on_time, random_bits(32));
         read_all();
      end

      // enable again, then on-time alone must clear it
      reg_write(pwm_config, random_bits(32) | 32'd1);
      reg_write(pwm_on_time, random_bits(32));
      read_all();

      repeat (12) waveform_trial();

      // one write outside the window
      pick       = random_bits(8);
      stray_addr = pick[7:0];
      if (stray_addr >= 8'd20 && stray_addr <= 8'd23) begin
         stray_addr = stray_addr + 8'd8;
      end
      bus_access(stray_addr, 1'b1, random_bits(32), ack_seen, data_seen);
      if (ack_seen) begin
         error_count++;
         $display("address %0d outside the window was acknowledged", stray_addr);
      end
      read_all();

      $display("checks=%0d errors=%0d", check_count, error_count);
      if (error_count == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: list.f
design/pwm_pkg.sv
design/bus_handshake.sv
design/pwm_registers.sv
design/pwm_timer.sv
design/h_bridge_drive.sv
design/pwm_channel.sv
sim/pwm_channel_tb.sv

// File: Makefile
# Verilator build and run for the PWM channel testbench

VERILATOR ?= verilator
TOP       ?= pwm_channel_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_TEXT ?= Test passed

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
